/* logic/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ***************************************************************************
// fetch stage constants
// ***************************************************************************

// width of an address and of an instruction word
`define FETCH_XLEN 32

// first address fetched once reset is released
`define FETCH_RESET_PC 32'h4000_0000

// word-address width of the instruction memory, which gives 256 words
// the byte address bits [IMEM_ADDR_BITS+1:2] select the word
`define IMEM_ADDR_BITS 8

// ***************************************************************************
// end of fetch stage constants
// ***************************************************************************

`endif

/* logic/fetch_pkg.sv */
`default_nettype none

`include "fetch_defs.svh"

package fetch_pkg;

    // ***********************************************************************
    // fetch address source
    // ***********************************************************************

    typedef enum logic [1:0] {
        PC_SEQ  = 2'd0,
        PC_EX   = 2'd1,
        PC_ID   = 2'd2,
        PC_HOLD = 2'd3
    } pc_sel_e;

    // taken target from a later stage, used for both execute and decode
    typedef struct packed {
        logic                   taken;
        logic [`FETCH_XLEN-1:0] target;
    } redirect_t;

    // what decode receives from the IF/ID register
    typedef struct packed {
        logic                   valid;
        logic [`FETCH_XLEN-1:0] pc;
        logic [`FETCH_XLEN-1:0] instr;
    } fetch_out_t;

endpackage

`default_nettype wire

/* logic/program_counter.sv */
`default_nettype none

`include "fetch_defs.svh"

// ***************************************************************************
// program counter
// ***************************************************************************

module program_counter (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   stall,
    input  logic [`FETCH_XLEN-1:0] pc_next,
    output logic [`FETCH_XLEN-1:0] pc
);

    // the PC is architectural state, so it comes out of reset at a known
    // fetch address and only moves on edges where decode accepts a word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `FETCH_RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // while stalled the value above is simply kept; the fetch address is
    // then taken from the IF/ID register rather than from here

endmodule

`default_nettype wire

/* logic/pc_control.sv */
`default_nettype none

`include "fetch_defs.svh"

// ***************************************************************************
// fetch address selection
// ***************************************************************************

module pc_control
    import fetch_pkg::*;
(
    input  logic                   stall,
    input  redirect_t              ex_redirect,
    input  redirect_t              id_redirect,
    input  logic [`FETCH_XLEN-1:0] seq_pc,
    input  logic [`FETCH_XLEN-1:0] held_pc,
    output pc_sel_e                fetch_sel,
    output logic [`FETCH_XLEN-1:0] fetch_addr
);

    // a stall beats every redirect, so upstream must keep its redirect
    // asserted until the stall drops
    always_comb begin
        if (stall) begin
            fetch_sel = PC_HOLD;
        end else if (ex_redirect.taken) begin
            fetch_sel = PC_EX;
        end else if (id_redirect.taken) begin
            fetch_sel = PC_ID;
        end else begin
            fetch_sel = PC_SEQ;
        end
    end

    // address follows the chosen source in the same cycle
    always_comb begin
        case (fetch_sel)
            PC_HOLD: fetch_addr = held_pc;
            PC_EX:   fetch_addr = ex_redirect.target;
            PC_ID:   fetch_addr = id_redirect.target;
            default: fetch_addr = seq_pc;
        endcase
    end

endmodule

`default_nettype wire

/* logic/inst_mem.sv */
`default_nettype none

`include "fetch_defs.svh"

// ***************************************************************************
// instruction memory
// ***************************************************************************

module inst_mem (
    input  logic                       clk,
    input  logic                       hold,
    input  logic [`FETCH_XLEN-1:0]     addr,
    input  logic                       load_en,
    input  logic [`IMEM_ADDR_BITS-1:0] load_addr,
    input  logic [`FETCH_XLEN-1:0]     load_data,
    output logic [`FETCH_XLEN-1:0]     rdata
);

    localparam int DEPTH = 1 << `IMEM_ADDR_BITS;

    logic [`FETCH_XLEN-1:0]     mem [DEPTH];
    logic [`IMEM_ADDR_BITS-1:0] rd_index;

    // word index from the byte address, the low two bits are always zero
    // for an aligned fetch
    assign rd_index = addr[`IMEM_ADDR_BITS+1:2];

    // ***********************************************************************
    // load port
    // ***********************************************************************

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ***********************************************************************
    // registered read
    // ***********************************************************************

    // the word lands on the same edge that moves the fetch address into
    // the IF/ID register, so pc and instr stay aligned
    // Under a stall the read register keeps the word decode is looking at
    always_ff @(posedge clk) begin
        if (!hold) begin
            rdata <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* logic/if_stage.sv */
`default_nettype none

`include "fetch_defs.svh"

// ***************************************************************************
// instruction fetch stage
// ***************************************************************************

module if_stage
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   id_stall,
    input  redirect_t              ex_redirect,
    input  redirect_t              id_redirect,
    input  logic [`FETCH_XLEN-1:0] imem_rdata,
    output logic [`FETCH_XLEN-1:0] fetch_addr,
    output fetch_out_t             id_out
);

    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] pc_plus4;
    logic [`FETCH_XLEN-1:0] ifid_pc;
    logic                   ifid_valid;
    logic                   hold;
    pc_sel_e                fetch_sel;

    // ***********************************************************************
    // address selection
    // ***********************************************************************

    pc_control u_pc_control (
        .stall       (id_stall),
        .ex_redirect (ex_redirect),
        .id_redirect (id_redirect),
        .seq_pc      (pc),
        .held_pc     (ifid_pc),
        .fetch_sel   (fetch_sel),
        .fetch_addr  (fetch_addr)
    );

    // the stall test lives in pc_control, everything here keys off its result
    assign hold = (fetch_sel == PC_HOLD);

    // ***********************************************************************
    // program counter
    // ***********************************************************************

    // next PC follows whatever was fetched this cycle, so a redirect
    // target is followed by target plus 4
    assign pc_plus4 = fetch_addr + `FETCH_XLEN'd4;

    program_counter u_program_counter (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (hold),
        .pc_next (pc_plus4),
        .pc      (pc)
    );

    // ***********************************************************************
    // IF/ID register
    // ***********************************************************************

    // valid rises on the first accepted edge after reset and then stays
    // up, since this stage has no flush of its own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ifid_valid <= 1'b0;
            ifid_pc    <= `FETCH_RESET_PC;
        end else if (!hold) begin
            ifid_valid <= 1'b1;
            ifid_pc    <= fetch_addr;
        end
    end

    // instr comes straight from the memory read register, which is
    // already aligned with ifid_pc
    always_comb begin
        id_out.valid = ifid_valid;
        id_out.pc    = ifid_pc;
        id_out.instr = imem_rdata;
    end

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`default_nettype none

`include "fetch_defs.svh"

// ***************************************************************************
// fetch stage with its instruction memory
// ***************************************************************************

module fetch_top
    import fetch_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       id_stall,
    input  redirect_t                  ex_redirect,
    input  redirect_t                  id_redirect,
    input  logic                       load_en,
    input  logic [`IMEM_ADDR_BITS-1:0] load_addr,
    input  logic [`FETCH_XLEN-1:0]     load_data,
    output logic [`FETCH_XLEN-1:0]     fetch_addr,
    output fetch_out_t                 id_out
);

    logic [`FETCH_XLEN-1:0] imem_rdata;

    // ***********************************************************************
    // fetch stage
    // ***********************************************************************

    if_stage u_if_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_stall    (id_stall),
        .ex_redirect (ex_redirect),
        .id_redirect (id_redirect),
        .imem_rdata  (imem_rdata),
        .fetch_addr  (fetch_addr),
        .id_out      (id_out)
    );

    // ***********************************************************************
    // instruction memory
    // ***********************************************************************

    // the memory reads the same fetch address the stage registers, and
    // holds its output word for as long as decode is stalled
    inst_mem u_inst_mem (
        .clk       (clk),
        .hold      (id_stall),
        .addr      (fetch_addr),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rdata     (imem_rdata)
    );

endmodule

`default_nettype wire

/* tb/fetch_tb.sv */
`default_nettype none

`include "fetch_defs.svh"

module fetch_tb
    import fetch_pkg::*;
();

    localparam int LOAD_CYCLES = (1 << `IMEM_ADDR_BITS) + 1;
    localparam int TEST_CYCLES = 350;

    bit                         clk;
    logic                       arst_n;
    logic                       id_stall;
    redirect_t                  ex_redirect;
    redirect_t                  id_redirect;
    logic                       load_en;
    logic [`IMEM_ADDR_BITS-1:0] load_addr;
    logic [`FETCH_XLEN-1:0]     load_data;
    logic [`FETCH_XLEN-1:0]     fetch_addr;
    fetch_out_t                 id_out;

    // reference model of the PC and the IF/ID register
    logic [`FETCH_XLEN-1:0] m_pc;
    logic                   m_valid;
    logic [`FETCH_XLEN-1:0] m_ifid_pc;
    logic [`FETCH_XLEN-1:0] m_instr;
    logic [`FETCH_XLEN-1:0] exp_addr;

    int pass_count;
    int fail_count;
    int test_start_fails;

    fetch_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .id_stall    (id_stall),
        .ex_redirect (ex_redirect),
        .id_redirect (id_redirect),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_addr  (fetch_addr),
        .id_out      (id_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ***********************************************************************
    // reference functions
    // ***********************************************************************

    // memory contents as a function of the word index
    function automatic logic [31:0] word_at(input logic [31:0] index);
        return (index * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [31:0] word_for_addr(input logic [31:0] addr);
        return word_at(32'(addr[`IMEM_ADDR_BITS+1:2]));
    endfunction

    // stall first, then mispredict, then decode target, then sequential
    function automatic logic [31:0] expected_fetch(input logic stall, input redirect_t ex,
                                                   input redirect_t id, input logic [31:0] pc,
                                                   input logic [31:0] held);
        if (stall) begin
            return held;
        end
        if (ex.taken) begin
            return ex.target;
        end
        if (id.taken) begin
            return id.target;
        end
        return pc;
    endfunction

    function automatic logic [31:0] random_target();
        return `FETCH_RESET_PC + (32'($urandom_range(0, 255)) << 2);
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp);
        fail_count = fail_count + 1;
    endtask

    // ***********************************************************************
    // comparing process
    // ***********************************************************************

    // inputs only move on rising edges, so the falling edge sees settled
    // values for both the registered outputs and the fetch address
    always @(negedge clk) begin
        if (!arst_n) begin
            m_pc      = `FETCH_RESET_PC;
            m_valid   = 1'b0;
            m_ifid_pc = `FETCH_RESET_PC;
        end
        if (id_out.valid !== m_valid)
            report_mismatch("id_out.valid", 32'(id_out.valid), 32'(m_valid));
        else
            pass_count = pass_count + 1;
        if (id_out.pc !== m_ifid_pc)
            report_mismatch("id_out.pc", id_out.pc, m_ifid_pc);
        else
            pass_count = pass_count + 1;
        if (m_valid && id_out.instr !== m_instr)
            report_mismatch("id_out.instr", id_out.instr, m_instr);
        else
            pass_count = pass_count + 1;
        exp_addr = expected_fetch(id_stall, ex_redirect, id_redirect, m_pc, m_ifid_pc);
        if (fetch_addr !== exp_addr)
            report_mismatch("fetch_addr", fetch_addr, exp_addr);
        else
            pass_count = pass_count + 1;
        // advance the model by the edge that follows
        if (arst_n && !id_stall) begin
            m_pc      = exp_addr + 32'd4;
            m_valid   = 1'b1;
            m_ifid_pc = exp_addr;
            m_instr   = word_for_addr(exp_addr);
        end
    end

    // ***********************************************************************
    // stimulus
    // ***********************************************************************

    task automatic drive(input logic stall, input logic ex_t, input logic [31:0] ex_tgt,
                         input logic id_t, input logic [31:0] id_tgt);
        @(posedge clk);
        id_stall           <= stall;
        ex_redirect.taken  <= ex_t;
        ex_redirect.target <= ex_tgt;
        id_redirect.taken  <= id_t;
        id_redirect.target <= id_tgt;
    endtask

    task automatic run_idle(input int cycles);
        repeat (cycles) drive(1'b0, 1'b0, 32'd0, 1'b0, 32'd0);
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d mismatches", name, fail_count - test_start_fails);
        test_start_fails = fail_count;
    endtask

    initial begin
        logic st;
        int   kind;

        void'($urandom(7));
        pass_count       = 0;
        fail_count       = 0;
        test_start_fails = 0;
        arst_n           = 1'b0;
        id_stall         = 1'b1;
        ex_redirect      = '0;
        id_redirect      = '0;
        load_en          = 1'b0;
        load_addr        = '0;
        load_data        = '0;

        // reset, then fill the memory while decode is stalled
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        for (int i = 0; i < (1 << `IMEM_ADDR_BITS); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= `IMEM_ADDR_BITS'(i);
            load_data <= word_at(32'(i));
        end
        @(posedge clk);
        load_en <= 1'b0;
        // the stall drops on the first of these edges, so the second one
        // is the first edge that moves the reset PC into IF/ID
        run_idle(2);
        @(negedge clk);
        if (!id_out.valid || id_out.pc !== `FETCH_RESET_PC)
            report_mismatch("first fetch pc", id_out.pc, `FETCH_RESET_PC);
        end_test("reset");

        run_idle(20);
        end_test("sequential");

        drive(1'b0, 1'b0, 32'd0, 1'b1, `FETCH_RESET_PC + 32'h200);
        run_idle(4);
        end_test("decode redirect");

        drive(1'b0, 1'b1, `FETCH_RESET_PC + 32'h080, 1'b1, `FETCH_RESET_PC + 32'h300);
        run_idle(4);
        end_test("execute over decode");

        // redirects during a stall are dropped unless still held afterwards
        drive(1'b1, 1'b1, `FETCH_RESET_PC + 32'h040, 1'b0, 32'd0);
        drive(1'b1, 1'b0, 32'd0, 1'b1, `FETCH_RESET_PC + 32'h0C0);
        drive(1'b1, 1'b1, `FETCH_RESET_PC + 32'h100, 1'b1, `FETCH_RESET_PC + 32'h140);
        drive(1'b1, 1'b0, 32'd0, 1'b0, 32'd0);
        run_idle(3);
        repeat (3) drive(1'b1, 1'b0, 32'd0, 1'b1, `FETCH_RESET_PC + 32'h3F0);
        drive(1'b0, 1'b0, 32'd0, 1'b1, `FETCH_RESET_PC + 32'h3F0);
        run_idle(3);
        end_test("stall");

        repeat (300) begin
            st   = ($urandom_range(0, 3) == 0);
            kind = $urandom_range(0, 5);
            drive(st, (kind == 0 || kind == 2), random_target(),
                  (kind == 1 || kind == 2), random_target());
        end
        run_idle(1);
        @(negedge clk);
        end_test("random");

        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ***********************************************************************
    // watchdog
    // ***********************************************************************

    initial begin
        #((LOAD_CYCLES + TEST_CYCLES + 20) * 20 * 2);
        $display("the run timed out before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/fetch_pkg.sv
logic/program_counter.sv
logic/pc_control.sv
logic/inst_mem.sv
logic/if_stage.sv
logic/fetch_top.sv
tb/fetch_tb.sv
